//--- list.f
hdl/issuer_pkg.sv
hdl/inflight_table.sv
hdl/parked_queue.sv
hdl/instr_sequencer.sv
hdl/issue_ctrl.sv
hdl/issuer_top.sv
testbench/issuer_assertions.sv
testbench/issuer_tb.sv

//--- testbench/issuer_tb.sv
// testbench for the command issuer
// random command source, processor models and a reference model
// compare tasks and the pass/fail report
`timescale 1ns/1ps

module issuer_tb
    import issuer_pkg::*;
();

    localparam int     N_CMDS    = 60;
    localparam int     TIMEOUT   = 20000;  // cycles, per wait
    localparam instr_t NOP_INSTR = '0;

    logic                  i_clk, i_rstn, i_empty_queue, o_rd_queue, o_finished_task;
    cmd_t                  i_cmd;
    logic [PROC_COUNT-1:0] i_busy_proc, i_finish_proc, o_en_proc, o_ack_proc;
    instr_t                o_instr;

    integer                seed;
    cmd_t                  cmds [N_CMDS];
    logic                  issued [N_CMDS];
    logic                  id_live [2**CMD_ID_W];  // taken from the queue, not finished yet
    int                    head_idx, issued_count, hit, cycles;
    logic                  feed_on, beats_on;
    logic [PROC_COUNT-1:0] busy_m, fin_m, run_valid;  // processor models
    int                    run_left [PROC_COUNT];
    logic [CMD_ID_W-1:0]   running_id [PROC_COUNT];
    int                    beat_n, seq_proc;
    instr_t                beats [4];

    issuer_top UUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // beat n of the sequence a command should produce
    function automatic instr_t expected_beat(input cmd_info_t info, input int n);
        instr_t e;
        e = '0;
        case (n)
            0: e = '{INSTR_LD, info.addr_0};
            1: e = '{INSTR_LD, info.addr_1};
            2: begin
                e.opcode                = INSTR_INFO;
                e.payload[1:0]          = info.op;
                e.payload[2 +: COUNT_W] = info.count;  // count sits above the op
            end
            default: e = '{INSTR_STORE, info.wr_addr};
        endcase
        return e;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("error at %0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic check_instr(input instr_t got, input instr_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_vec(input logic [PROC_COUNT-1:0] got, exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ids cycle 1..15, about half depend on one of the last four commands
    task automatic build_commands();
        int back;
        for (int i = 0; i < N_CMDS; i++) begin
            cmds[i].id  = CMD_ID_W'((i % 15) + 1);
            cmds[i].dep = NO_DEP;
            if (i >= 4 && ($random(seed) & 1)) begin
                back        = 1 + ($unsigned($random(seed)) % 4);
                cmds[i].dep = cmds[i - back].id;
            end
            cmds[i].info.op      = op_e'($unsigned($random(seed)) % 4);
            cmds[i].info.addr_0  = ADDR_W'($random(seed));
            cmds[i].info.addr_1  = ADDR_W'($random(seed));
            cmds[i].info.wr_addr = ADDR_W'($random(seed));
            cmds[i].info.count   = COUNT_W'($random(seed));
        end
    endtask

    // find the waiting command behind the four captured beats
    task automatic match_sequence();
        hit = -1;
        for (int k = 0; k < head_idx; k++) begin
            if (hit < 0 && !issued[k] && expected_beat(cmds[k].info, 0) === beats[0]
                    && expected_beat(cmds[k].info, 3) === beats[3]) begin
                hit = k;
            end
        end
        if (hit < 0) begin
            report_error("instruction sequence matches no command waiting to issue");
        end else begin
            check_instr(beats[1], expected_beat(cmds[hit].info, 1), "second load beat");
            check_instr(beats[2], expected_beat(cmds[hit].info, 2), "info beat");
            for (int q = 0; q < PROC_COUNT; q++) begin
                if (run_valid[q] && cmds[hit].dep != NO_DEP && running_id[q] == cmds[hit].dep) begin
                    report_error("command enabled while its dependency is running");
                end
            end
            issued[hit]          = 1'b1;
            issued_count++;
            running_id[seq_proc] = cmds[hit].id;
            run_valid[seq_proc]  = 1'b1;
        end
    endtask

    // one clock of the reference model, outputs sampled at the falling edge
    task automatic observe_cycle();
        logic [PROC_COUNT-1:0] want;
        int p;
        want = ~i_busy_proc & (i_busy_proc + 1'b1);  // lowest free processor
        if (o_rd_queue) begin
            check_flag(i_empty_queue, 1'b0, "queue read");
            id_live[cmds[head_idx].id] = 1'b1;
            head_idx++;
        end
        for (int q = 0; q < PROC_COUNT; q++) begin
            if (busy_m[q] && !fin_m[q]) begin
                run_left[q]--;
                fin_m[q] = (run_left[q] == 0);
            end
        end
        if (o_en_proc != '0) begin
            check_flag(beats_on, 1'b0, "enable during an instruction sequence");
            check_vec(o_en_proc, want, "enable target");
            check_vec(o_ack_proc, '0, "ack in the enable cycle");
            check_instr(o_instr, NOP_INSTR, "instruction bus in the enable cycle");
            seq_proc           = $clog2(o_en_proc);
            busy_m[seq_proc]   = 1'b1;               // busy from the next cycle
            run_left[seq_proc] = 5 + ($unsigned($random(seed)) % 36);
            beats_on           = 1'b1;
            beat_n             = 0;
        end else if (beats_on) begin
            check_vec(o_ack_proc, PROC_COUNT'(1) << seq_proc, "beat ack");
            beats[beat_n] = o_instr;
            beat_n++;
            if (beat_n == 4) begin
                beats_on = 1'b0;
                match_sequence();
            end
        end else if (o_ack_proc != '0) begin
            check_flag($onehot(o_ack_proc), 1'b1, "finish ack one-hot");
            check_instr(o_instr, NOP_INSTR, "finish ack instruction");
            p               = $clog2(o_ack_proc);
            check_flag(fin_m[p], 1'b1, "finish ack to a finishing processor");
            id_live[running_id[p]] = 1'b0;
            busy_m[p]       = 1'b0;
            fin_m[p]        = 1'b0;
            run_valid[p]    = 1'b0;
        end else begin
            check_instr(o_instr, NOP_INSTR, "idle instruction bus");
        end
    endtask

    // model at the falling edge, inputs 2 ns after the rising edge
    always begin
        @(negedge i_clk);
        if (i_rstn) observe_cycle();
        @(posedge i_clk);
        #2;
        i_busy_proc   = busy_m;
        i_finish_proc = fin_m;
        i_cmd         = (head_idx < N_CMDS) ? cmds[head_idx] : '0;
        // head held back while an earlier command with its id is live
        i_empty_queue = !feed_on || head_idx >= N_CMDS || id_live[i_cmd.id];
    end

    always @(UUT.u_ctrl.u_assert.fail_count) begin
        if (UUT.u_ctrl.u_assert.fail_count != 0) begin
            report_error("protocol assertion on the controller failed");
        end
    end

    initial begin
        seed          = 32'h7bf9_0c18;
        i_rstn        = 1'b0;
        i_cmd         = '0;
        i_empty_queue = 1'b1;
        i_busy_proc   = '0;
        i_finish_proc = '0;
        feed_on       = 1'b0;
        beats_on      = 1'b0;
        busy_m        = '0;
        fin_m         = '0;
        run_valid     = '0;
        head_idx      = 0;
        issued_count  = 0;
        foreach (issued[k]) issued[k] = 1'b0;
        foreach (id_live[k]) id_live[k] = 1'b0;
        build_commands();
        repeat (16) @(posedge i_clk);
        check_flag(o_rd_queue, 1'b0, "queue read in reset");
        check_vec(o_en_proc | o_ack_proc, '0, "enable or ack in reset");
        check_instr(o_instr, NOP_INSTR, "instruction bus in reset");
        #2;
        i_rstn = 1'b1;
        repeat (4) begin
            @(negedge i_clk);
            check_flag(o_finished_task, 1'b1, "finished flag with an empty queue");
        end
        feed_on = 1'b1;
        for (cycles = 0; issued_count < N_CMDS && cycles < TIMEOUT; cycles++) begin
            @(negedge i_clk);
        end
        if (issued_count < N_CMDS) report_error("timeout waiting for all commands to issue");
        for (cycles = 0; o_finished_task !== 1'b1 && cycles < TIMEOUT; cycles++) begin
            @(negedge i_clk);
        end
        if (o_finished_task !== 1'b1) report_error("timeout waiting for the finished flag");
        if (UUT.u_ctrl.u_assert.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

//--- testbench/issuer_assertions.sv
// concurrent checks on the issue controller
// one-hot enable, ack overlap, queue read vs empty
`timescale 1ns/1ps

module issuer_assertions
    import issuer_pkg::*;
(
    input logic                  i_clk,
    input logic                  i_rstn,
    input logic [PROC_COUNT-1:0] o_en_proc,
    input logic [PROC_COUNT-1:0] o_fin_ack,
    input logic                  i_seq_busy,
    input logic                  o_rd_queue,
    input logic                  i_empty_queue
);

    int fail_count = 0;  // failed assertions so far

    en_onehot: assert property (@(posedge i_clk) disable iff (!i_rstn) $onehot0(o_en_proc))
        else begin
            fail_count++;
            $error("enable is not one-hot");
        end

    // sequencer beats and finish acks share o_ack_proc
    ack_overlap: assert property (@(posedge i_clk) disable iff (!i_rstn)
            !(i_seq_busy && |o_fin_ack))
        else begin
            fail_count++;
            $error("finish ack while the sequencer is busy");
        end

    rd_not_empty: assert property (@(posedge i_clk) disable iff (!i_rstn)
            o_rd_queue |-> !i_empty_queue)
        else begin
            fail_count++;
            $error("queue read while the queue is empty");
        end

endmodule

bind issue_ctrl issuer_assertions u_assert (
    .i_clk, .i_rstn, .o_en_proc, .o_fin_ack, .i_seq_busy, .o_rd_queue, .i_empty_queue
);

//--- hdl/issuer_top.sv
// command issuer top level
// controller, inflight table, parked queue and instruction sequencer
`timescale 1ns/1ps

module issuer_top
    import issuer_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rstn,
    input  cmd_t                  i_cmd,
    input  logic                  i_empty_queue,
    output logic                  o_rd_queue,
    input  logic [PROC_COUNT-1:0] i_busy_proc,
    input  logic [PROC_COUNT-1:0] i_finish_proc,
    output logic [PROC_COUNT-1:0] o_en_proc,
    output logic [PROC_COUNT-1:0] o_ack_proc,
    output instr_t                o_instr,
    output logic                  o_finished_task
);

    logic                  set, clear, dep_running;
    logic [PROC_IDX_W-1:0] proc_idx, seq_proc;
    logic [CMD_ID_W-1:0]   set_id, dep_id;
    logic                  push, pop, park_empty, park_full;
    cmd_t                  park_cmd, park_head;
    logic [PARK_CNT_W-1:0] park_count;
    logic                  seq_start, seq_busy;
    cmd_info_t             seq_info;
    logic [PROC_COUNT-1:0] fin_ack, seq_ack;

    issue_ctrl u_ctrl (
        .i_clk, .i_rstn, .i_cmd, .i_empty_queue, .o_rd_queue,
        .i_busy_proc, .i_finish_proc, .o_en_proc,
        .o_fin_ack(fin_ack), .o_set(set), .o_clear(clear), .o_proc_idx(proc_idx),
        .o_set_id(set_id), .o_dep_id(dep_id), .i_dep_running(dep_running),
        .o_push(push), .o_pop(pop), .o_park_cmd(park_cmd), .i_park_head(park_head),
        .i_park_empty(park_empty), .i_park_full(park_full), .i_park_count(park_count),
        .o_seq_start(seq_start), .o_seq_info(seq_info), .o_seq_proc(seq_proc),
        .i_seq_busy(seq_busy), .o_finished_task
    );

    inflight_table u_table (
        .i_clk, .i_rstn, .i_set(set), .i_clear(clear), .i_proc_idx(proc_idx),
        .i_set_id(set_id), .i_dep_id(dep_id), .o_dep_running(dep_running)
    );

    parked_queue #(.DEPTH(PARKED_DEPTH)) u_parked (
        .i_clk, .i_rstn, .i_push(push), .i_pop(pop), .i_cmd(park_cmd),
        .o_head(park_head), .o_empty(park_empty), .o_full(park_full), .o_count(park_count)
    );

    instr_sequencer u_seq (
        .i_clk, .i_rstn, .i_start(seq_start), .i_info(seq_info), .i_proc_idx(seq_proc),
        .o_ack_proc(seq_ack), .o_instr, .o_busy(seq_busy)
    );

    // finish acks only happen while the sequencer is idle
    assign o_ack_proc = seq_ack | fin_ack;

endmodule

//--- hdl/issue_ctrl.sv
// issue controller FSM
// finish handling, retry budget for parked commands
// lowest finishing / lowest free processor priority pick
// park or issue decision and table/sequencer strobes
`timescale 1ns/1ps

module issue_ctrl
    import issuer_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rstn,
    // outside queue
    input  cmd_t                  i_cmd,
    input  logic                  i_empty_queue,
    output logic                  o_rd_queue,
    // processors
    input  logic [PROC_COUNT-1:0] i_busy_proc,
    input  logic [PROC_COUNT-1:0] i_finish_proc,
    output logic [PROC_COUNT-1:0] o_en_proc,
    output logic [PROC_COUNT-1:0] o_fin_ack,
    // inflight table
    output logic                  o_set,
    output logic                  o_clear,
    output logic [PROC_IDX_W-1:0] o_proc_idx,
    output logic [CMD_ID_W-1:0]   o_set_id,
    output logic [CMD_ID_W-1:0]   o_dep_id,
    input  logic                  i_dep_running,
    // parked queue
    output logic                  o_push,
    output logic                  o_pop,
    output cmd_t                  o_park_cmd,
    input  cmd_t                  i_park_head,
    input  logic                  i_park_empty,
    input  logic                  i_park_full,
    input  logic [PARK_CNT_W-1:0] i_park_count,
    // sequencer
    output logic                  o_seq_start,
    output cmd_info_t             o_seq_info,
    output logic [PROC_IDX_W-1:0] o_seq_proc,
    input  logic                  i_seq_busy,
    output logic                  o_finished_task
);

    issue_state_e          state;
    cmd_t                  cur_cmd;      // command under check / issue
    logic [PROC_IDX_W-1:0] proc_sel;     // finishing or target processor
    logic                  from_parked;
    logic [PARK_CNT_W-1:0] budget;       // parked entries left to retry
    logic [PROC_COUNT-1:0] proc_onehot;
    logic [PROC_IDX_W-1:0] fin_idx;
    logic [PROC_IDX_W-1:0] free_idx;
    logic                  any_free;
    logic                  take_parked;
    logic                  take_queue;

    // lowest set bit wins
    function automatic logic [PROC_IDX_W-1:0] lowest_set(input logic [PROC_COUNT-1:0] vec);
        logic [PROC_IDX_W-1:0] idx;
        idx = '0;
        for (int i = PROC_COUNT - 1; i >= 0; i--) begin
            if (vec[i]) idx = PROC_IDX_W'(i);
        end
        return idx;
    endfunction

    assign fin_idx     = lowest_set(i_finish_proc);
    assign free_idx    = lowest_set(~i_busy_proc);
    assign any_free    = ~&i_busy_proc;
    assign take_parked = any_free && (budget != '0) && !i_park_empty;
    assign take_queue  = any_free && !i_empty_queue && !i_park_full;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state       <= IDLE;
            proc_sel    <= '0;
            from_parked <= 1'b0;
            budget      <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (|i_finish_proc) begin             // finish first
                        proc_sel <= fin_idx;
                        state    <= FINISH_ACK;
                    end else if (take_parked) begin       // then parked retries
                        proc_sel    <= free_idx;
                        from_parked <= 1'b1;
                        budget      <= budget - 1'b1;
                        state       <= CMD_GET;
                    end else if (take_queue) begin
                        proc_sel    <= free_idx;
                        from_parked <= 1'b0;
                        state       <= CMD_GET;
                    end
                end
                FINISH_ACK: begin
                    budget <= i_park_count;  // retry everything parked so far
                    state  <= IDLE;
                end
                CMD_GET:   state <= CMD_CHECK;
                CMD_CHECK: state <= i_dep_running ? PARK : ISSUE;
                PARK:      state <= IDLE;
                ISSUE:     state <= WAIT_SEQ;
                WAIT_SEQ: begin
                    if (!i_seq_busy) state <= IDLE;
                end
                default:   state <= IDLE;
            endcase
        end
    end

    // command register, taken with the read or pop
    always_ff @(posedge i_clk) begin
        if (state == CMD_GET) begin
            cur_cmd <= from_parked ? i_park_head : i_cmd;
        end
    end

    assign proc_onehot = PROC_COUNT'(1) << proc_sel;

    assign o_rd_queue  = (state == CMD_GET) && !from_parked;
    assign o_pop       = (state == CMD_GET) && from_parked;
    assign o_push      = (state == PARK);   // re-park goes to the tail
    assign o_park_cmd  = cur_cmd;

    assign o_en_proc   = (state == ISSUE) ? proc_onehot : '0;
    assign o_fin_ack   = (state == FINISH_ACK) ? proc_onehot : '0;

    assign o_set       = (state == ISSUE);
    assign o_clear     = (state == FINISH_ACK);
    assign o_proc_idx  = proc_sel;
    assign o_set_id    = cur_cmd.id;
    assign o_dep_id    = cur_cmd.dep;

    assign o_seq_start = (state == ISSUE);
    assign o_seq_info  = cur_cmd.info;
    assign o_seq_proc  = proc_sel;

    assign o_finished_task = (state == IDLE) && ~|i_busy_proc && i_park_empty;

endmodule

//--- hdl/instr_sequencer.sv
// four-beat instruction sequencer for one processor
// ld addr_0, ld addr_1, info op/count, store wr_addr
// one-hot ack per beat, busy level across the beats
`timescale 1ns/1ps

module instr_sequencer
    import issuer_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rstn,
    input  logic                  i_start,
    input  cmd_info_t             i_info,
    input  logic [PROC_IDX_W-1:0] i_proc_idx,
    output logic [PROC_COUNT-1:0] o_ack_proc,
    output instr_t                o_instr,
    output logic                  o_busy
);

    localparam logic [1:0] LAST_BEAT = 2'd3;

    logic                  active;
    logic [1:0]            beat;     // 0..3, order of the sequence
    cmd_info_t             info_q;
    logic [PROC_IDX_W-1:0] proc_q;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            active <= 1'b0;
            beat   <= '0;
        end else if (i_start) begin
            active <= 1'b1;
            beat   <= '0;
        end else if (active) begin
            beat <= beat + 1'b1;
            if (beat == LAST_BEAT) active <= 1'b0;
        end
    end

    // latched with the start pulse
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            info_q <= i_info;
            proc_q <= i_proc_idx;
        end
    end

    assign o_busy     = active;
    assign o_ack_proc = active ? (PROC_COUNT'(1) << proc_q) : '0;

    always_comb begin
        o_instr = '0; // nop when idle
        if (active) begin
            case (beat)
                2'd0: begin
                    o_instr.opcode  = INSTR_LD;
                    o_instr.payload = info_q.addr_0;
                end
                2'd1: begin
                    o_instr.opcode  = INSTR_LD;
                    o_instr.payload = info_q.addr_1;
                end
                2'd2: begin
                    o_instr.opcode  = INSTR_INFO;
                    o_instr.payload = ADDR_W'({info_q.count, info_q.op}); // op in low bits
                end
                default: begin
                    o_instr.opcode  = INSTR_STORE;
                    o_instr.payload = info_q.wr_addr;
                end
            endcase
        end
    end

endmodule

//--- hdl/parked_queue.sv
// circular FIFO of commands waiting on a running dependency
// first-word-fall-through head, occupancy count, full and empty flags
`timescale 1ns/1ps

module parked_queue
    import issuer_pkg::*;
#(
    parameter int DEPTH = PARKED_DEPTH  // power of two
) (
    input  logic                   i_clk,
    input  logic                   i_rstn,
    input  logic                   i_push,
    input  logic                   i_pop,
    input  cmd_t                   i_cmd,
    output cmd_t                   o_head,
    output logic                   o_empty,
    output logic                   o_full,
    output logic [$clog2(DEPTH):0] o_count
);

    localparam int PTR_W = $clog2(DEPTH);

    cmd_t             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign o_empty = (count == '0);
    assign o_full  = (count == DEPTH[PTR_W:0]);
    assign o_count = count;
    assign o_head  = mem[rd_ptr];   // fall-through head

    // push into a full queue only when a pop frees the slot
    assign do_pop  = i_pop && !o_empty;
    assign do_push = i_push && (!o_full || do_pop);

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_cmd;
        end
    end

endmodule

//--- hdl/inflight_table.sv
// per-processor table of running command ids
// set on issue, clear on finish ack
// combinational lookup of a dependency id against valid entries
`timescale 1ns/1ps

module inflight_table
    import issuer_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rstn,
    input  logic                  i_set,        // record i_set_id on i_proc_idx
    input  logic                  i_clear,      // drop entry of i_proc_idx
    input  logic [PROC_IDX_W-1:0] i_proc_idx,
    input  logic [CMD_ID_W-1:0]   i_set_id,
    input  logic [CMD_ID_W-1:0]   i_dep_id,
    output logic                  o_dep_running
);

    logic [PROC_COUNT-1:0] entry_valid;
    logic [CMD_ID_W-1:0]   entry_id [PROC_COUNT];

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            entry_valid <= '0;
        end else begin
            if (i_set) begin
                entry_valid[i_proc_idx] <= 1'b1;
            end else if (i_clear) begin
                entry_valid[i_proc_idx] <= 1'b0;
            end
        end
    end

    // id storage, only meaningful while valid
    always_ff @(posedge i_clk) begin
        if (i_set) begin
            entry_id[i_proc_idx] <= i_set_id;
        end
    end

    // dependency lookup
    always_comb begin
        o_dep_running = 1'b0;
        if (i_dep_id != NO_DEP) begin
            for (int p = 0; p < PROC_COUNT; p++) begin
                if (entry_valid[p] && (entry_id[p] == i_dep_id)) begin
                    o_dep_running = 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/issuer_pkg.sv
// shared widths and sizes for the command issuer
// command, payload and instruction structs
// operation, instruction opcode and controller state enums
package issuer_pkg;

    localparam int PROC_COUNT   = 4;
    localparam int PROC_IDX_W   = 2;
    localparam int CMD_ID_W     = 4;
    localparam int ADDR_W       = 10;
    localparam int COUNT_W      = 6;
    localparam int PARKED_DEPTH = 8;
    localparam int PARK_CNT_W   = $clog2(PARKED_DEPTH) + 1; // 0..DEPTH inclusive

    localparam logic [CMD_ID_W-1:0] NO_DEP = '0; // reserved, never a real id

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2,
        OP_MAC = 2'd3
    } op_e;

    // operation payload, 38 bits
    typedef struct packed {
        op_e                op;
        logic [ADDR_W-1:0]  addr_0;
        logic [ADDR_W-1:0]  addr_1;
        logic [ADDR_W-1:0]  wr_addr;
        logic [COUNT_W-1:0] count;
    } cmd_info_t;

    // full command from the outside queue, 46 bits
    typedef struct packed {
        logic [CMD_ID_W-1:0] id;
        logic [CMD_ID_W-1:0] dep;   // NO_DEP when independent
        cmd_info_t           info;
    } cmd_t;

    typedef enum logic [1:0] {
        INSTR_NOP   = 2'd0,
        INSTR_LD    = 2'd1,
        INSTR_INFO  = 2'd2,
        INSTR_STORE = 2'd3
    } instr_opcode_e;

    // info payload is {pad, count, op}
    typedef struct packed {
        instr_opcode_e     opcode;
        logic [ADDR_W-1:0] payload;
    } instr_t;

    typedef enum logic [2:0] {
        IDLE, FINISH_ACK, CMD_GET, CMD_CHECK, PARK, ISSUE, WAIT_SEQ
    } issue_state_e;

endpackage
